// File: Makefile
# Verilator build and run of the DS18B20 reader testbench

VERILATOR ?= verilator
TOP       ?= tb_ds18b20_reader
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= No errors

SOURCES := $(shell grep -v '^+' $(FILELIST))
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: design/ds18b20_reader.sv
`timescale 1ns/1ps
`default_nettype none

module ds18b20_reader #(
  parameter int CLK_PER_US   = 20,
  parameter int CONV_WAIT_US = 750000
) (
  input  logic        clk,
  input  logic        rstn,
  input  logic        bus_in,
  output logic        bus_pull_low,  // open-drain enable
  output logic        temp_valid,
  output logic        no_device,
  output logic [15:0] temperature
);

  import onewire_pkg::*;

  logic             us_tick;
  logic             slot_start;
  logic             slot_done;
  logic             rx_bit;
  logic             present;
  logic             raw_valid;
  slot_op_t         slot_op;
  logic [RAW_W-1:0] raw_word;

  // --------------------
  us_tick_gen #(
    .CLK_PER_US (CLK_PER_US)
  ) i_tick_gen (
    .clk     (clk),
    .rstn    (rstn),
    .us_tick (us_tick)
  );

  ds18b20_sequencer #(
    .CONV_WAIT_US (CONV_WAIT_US)
  ) i_sequencer (
    .clk        (clk),
    .rstn       (rstn),
    .us_tick    (us_tick),
    .slot_done  (slot_done),
    .rx_bit     (rx_bit),
    .present    (present),
    .slot_start (slot_start),
    .slot_op    (slot_op),
    .raw_word   (raw_word),
    .raw_valid  (raw_valid),
    .no_device  (no_device)
  );

  onewire_slot_engine i_slot_engine (
    .clk          (clk),
    .rstn         (rstn),
    .us_tick      (us_tick),
    .slot_start   (slot_start),
    .slot_op      (slot_op),
    .bus_in       (bus_in),
    .bus_pull_low (bus_pull_low),
    .slot_done    (slot_done),
    .rx_bit       (rx_bit),
    .present      (present)
  );

  temp_formatter i_formatter (
    .clk         (clk),
    .rstn        (rstn),
    .raw_valid   (raw_valid),
    .raw_word    (raw_word),
    .temperature (temperature),
    .temp_valid  (temp_valid)
  );

endmodule

`default_nettype wire

// File: design/ds18b20_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module ds18b20_sequencer #(
  parameter int CONV_WAIT_US = 750000
) (
  input  logic                              clk,
  input  logic                              rstn,
  input  logic                              us_tick,
  input  logic                              slot_done,
  input  logic                              rx_bit,
  input  logic                              present,
  output logic                              slot_start,
  output onewire_pkg::slot_op_t             slot_op,
  output logic [onewire_pkg::RAW_W-1:0]     raw_word,
  output logic                              raw_valid,
  output logic                              no_device
);

  import onewire_pkg::*;

  localparam logic [US_W-1:0] CONV_LAST = US_W'(CONV_WAIT_US - 1);
  localparam logic [3:0]      BIT_LAST  = 4'(RAW_W - 1);

  seq_state_t      state;
  logic            waiting;   // a slot is outstanding
  logic            byte_idx;  // 0 = skip rom, 1 = function command
  logic [3:0]      bit_idx;
  logic [US_W-1:0] conv_cnt;
  logic [7:0]      tx_byte;
  logic            needs_slot;
  logic            slot_ack;
  slot_op_t        next_op;

  // --------------------
  // next slot request
  always_comb
  begin
    tx_byte = CMD_SKIP_ROM;
    if (byte_idx)
      tx_byte = (state == SEQ_CMD1) ? CMD_CONVERT_T : CMD_READ_SCRATCH;

    needs_slot = 1'b1;
    next_op    = SLOT_RESET;
    case (state)
      SEQ_CMD1, SEQ_CMD2:
        next_op = tx_byte[bit_idx[2:0]] ? SLOT_WRITE1 : SLOT_WRITE0;  // lsb first
      SEQ_READ:
        next_op = SLOT_READ;
      SEQ_CONV_WAIT, SEQ_FORMAT:
        needs_slot = 1'b0;
      default:
        next_op = SLOT_RESET;
    endcase
  end

  assign slot_ack = waiting & slot_done;

  // --------------------
  // command cycle
  always_ff @(posedge clk or negedge rstn)
  begin
    if (!rstn)
    begin
      state      <= SEQ_RESET1;
      waiting    <= 1'b0;
      byte_idx   <= 1'b0;
      bit_idx    <= '0;
      conv_cnt   <= '0;
      slot_start <= 1'b0;
      slot_op    <= SLOT_RESET;
      raw_valid  <= 1'b0;
      no_device  <= 1'b0;
    end
    else
    begin
      slot_start <= 1'b0;
      raw_valid  <= 1'b0;
      no_device  <= 1'b0;

      if (needs_slot && !waiting)
      begin
        slot_start <= 1'b1;
        slot_op    <= next_op;
        waiting    <= 1'b1;
      end
      if (slot_ack)
        waiting <= 1'b0;

      case (state)
        SEQ_RESET1, SEQ_RESET2:
          if (slot_ack)
          begin
            byte_idx <= 1'b0;
            bit_idx  <= '0;
            if (present)
              state <= (state == SEQ_RESET1) ? SEQ_CMD1 : SEQ_CMD2;
            else
            begin
              no_device <= 1'b1;  // no answer, start over
              state     <= SEQ_RESET1;
            end
          end
        SEQ_CMD1, SEQ_CMD2:
          if (slot_ack)
          begin
            bit_idx <= bit_idx + 1'b1;
            if (bit_idx == 4'd7)
            begin
              bit_idx  <= '0;
              byte_idx <= ~byte_idx;
              if (byte_idx)
              begin
                conv_cnt <= '0;
                state    <= (state == SEQ_CMD1) ? SEQ_CONV_WAIT : SEQ_READ;
              end
            end
          end
        SEQ_CONV_WAIT:
          if (us_tick)
          begin
            if (conv_cnt == CONV_LAST)
            begin
              conv_cnt <= '0;
              state    <= SEQ_RESET2;
            end
            else
              conv_cnt <= conv_cnt + 1'b1;
          end
        SEQ_READ:
          if (slot_ack)
          begin
            bit_idx <= bit_idx + 1'b1;
            if (bit_idx == BIT_LAST)
            begin
              bit_idx <= '0;
              state   <= SEQ_FORMAT;
            end
          end
        default:
        begin
          raw_valid <= 1'b1;  // word complete
          state     <= SEQ_RESET1;
        end
      endcase
    end
  end

  // read bits arrive lsb first
  always_ff @(posedge clk)
  begin
    if ((state == SEQ_READ) && slot_ack)
      raw_word <= {rx_bit, raw_word[RAW_W-1:1]};
  end

endmodule

`default_nettype wire

// File: design/onewire_pkg.sv
`default_nettype none

package onewire_pkg;

  localparam int RAW_W = 16;  // scratchpad temperature word
  localparam int US_W  = 20;  // microsecond counter width

  // --------------------
  // slot opcodes and sequencer states
  typedef enum logic [1:0] {
    SLOT_RESET,
    SLOT_WRITE0,
    SLOT_WRITE1,
    SLOT_READ
  } slot_op_t;

  typedef enum logic [2:0] {
    SEQ_RESET1,     // reset before convert
    SEQ_CMD1,       // skip rom + convert t
    SEQ_CONV_WAIT,
    SEQ_RESET2,     // reset before read
    SEQ_CMD2,       // skip rom + read scratchpad
    SEQ_READ,
    SEQ_FORMAT
  } seq_state_t;

  // --------------------
  // DS18B20 function commands
  localparam logic [7:0] CMD_SKIP_ROM     = 8'hCC;
  localparam logic [7:0] CMD_CONVERT_T    = 8'h44;
  localparam logic [7:0] CMD_READ_SCRATCH = 8'hBE;

  // --------------------
  // slot timing in microseconds
  localparam logic [US_W-1:0] RESET_LOW_US       = 20'd500;
  localparam logic [US_W-1:0] PRESENCE_SAMPLE_US = 20'd70;   // release to presence sample
  localparam logic [US_W-1:0] RESET_TAIL_US      = 20'd410;
  localparam logic [US_W-1:0] WRITE_SLOT_US      = 20'd80;
  localparam logic [US_W-1:0] READ_LOW_US        = 20'd2;    // also write-1 low time
  localparam logic [US_W-1:0] READ_SAMPLE_US     = 20'd10;
  localparam logic [US_W-1:0] READ_TAIL_US       = 20'd55;
  localparam logic [US_W-1:0] RECOVERY_US        = 20'd2;    // released gap after each slot

endpackage

`default_nettype wire

// File: design/onewire_slot_engine.sv
`timescale 1ns/1ps
`default_nettype none

module onewire_slot_engine (
  input  logic                 clk,
  input  logic                 rstn,
  input  logic                 us_tick,
  input  logic                 slot_start,
  input  onewire_pkg::slot_op_t slot_op,
  input  logic                 bus_in,
  output logic                 bus_pull_low,
  output logic                 slot_done,
  output logic                 rx_bit,
  output logic                 present
);

  import onewire_pkg::*;

  typedef enum logic [2:0] {
    PH_IDLE,
    PH_ARM,     // waiting for the next tick to open the slot
    PH_LOW,
    PH_SAMPLE,  // released, counting to the sample point
    PH_TAIL
  } phase_t;

  phase_t          phase;
  slot_op_t        op_q;
  logic [US_W-1:0] us_cnt;
  logic [US_W-1:0] low_last;
  logic [US_W-1:0] samp_last;
  logic [US_W-1:0] tail_last;
  logic            has_sample;
  logic            samp_hit;

  // --------------------
  // slot shape per opcode, as last tick index of each phase
  always_comb
  begin
    low_last   = READ_LOW_US - 1'b1;
    samp_last  = READ_SAMPLE_US - 1'b1;
    tail_last  = READ_TAIL_US + RECOVERY_US - 1'b1;
    has_sample = 1'b1;
    case (op_q)
      SLOT_RESET:
      begin
        low_last  = RESET_LOW_US - 1'b1;
        samp_last = PRESENCE_SAMPLE_US - 1'b1;
        tail_last = RESET_TAIL_US - 1'b1;
      end
      SLOT_WRITE0:
      begin
        low_last   = WRITE_SLOT_US - 1'b1;
        tail_last  = RECOVERY_US - 1'b1;
        has_sample = 1'b0;
      end
      SLOT_WRITE1:
      begin
        tail_last  = WRITE_SLOT_US - READ_LOW_US + RECOVERY_US - 1'b1;
        has_sample = 1'b0;
      end
      default:
      begin
        has_sample = 1'b1;  // read slot keeps the defaults
      end
    endcase
  end

  assign samp_hit = (phase == PH_SAMPLE) && us_tick && (us_cnt == samp_last);

  // --------------------
  // phase sequencing
  always_ff @(posedge clk or negedge rstn)
  begin
    if (!rstn)
    begin
      phase        <= PH_IDLE;
      op_q         <= SLOT_RESET;
      us_cnt       <= '0;
      bus_pull_low <= 1'b0;
      slot_done    <= 1'b0;
    end
    else
    begin
      slot_done <= 1'b0;
      case (phase)
        PH_IDLE:
          if (slot_start)
          begin
            op_q  <= slot_op;
            phase <= PH_ARM;
          end
        PH_ARM:
          if (us_tick)
          begin
            bus_pull_low <= 1'b1;  // slot opens on the tick
            us_cnt       <= '0;
            phase        <= PH_LOW;
          end
        PH_LOW:
          if (us_tick)
          begin
            if (us_cnt == low_last)
            begin
              bus_pull_low <= 1'b0;
              us_cnt       <= '0;
              phase        <= has_sample ? PH_SAMPLE : PH_TAIL;
            end
            else
              us_cnt <= us_cnt + 1'b1;
          end
        PH_SAMPLE:
          if (us_tick)
          begin
            if (samp_hit)
            begin
              us_cnt <= '0;
              phase  <= PH_TAIL;
            end
            else
              us_cnt <= us_cnt + 1'b1;
          end
        PH_TAIL:
          if (us_tick)
          begin
            if (us_cnt == tail_last)
            begin
              slot_done <= 1'b1;  // one clk after the last tick
              phase     <= PH_IDLE;
            end
            else
              us_cnt <= us_cnt + 1'b1;
          end
        default:
          phase <= PH_IDLE;
      endcase
    end
  end

  // bus sample, held until the next sample point
  always_ff @(posedge clk)
  begin
    if (samp_hit)
    begin
      rx_bit  <= bus_in;
      present <= ~bus_in;  // device pulls low to answer
    end
  end

endmodule

`default_nettype wire

// File: design/temp_formatter.sv
`timescale 1ns/1ps
`default_nettype none

module temp_formatter (
  input  logic                          clk,
  input  logic                          rstn,
  input  logic                          raw_valid,
  input  logic [onewire_pkg::RAW_W-1:0] raw_word,
  output logic [15:0]                   temperature,
  output logic                          temp_valid
);

  import onewire_pkg::*;

  logic             sign;
  logic [RAW_W-1:0] mag;
  logic [6:0]       int_part;   // whole degrees
  logic [6:0]       tens;
  logic [6:0]       units;
  logic [7:0]       frac_x10;   // upper nibble is the tenths digit

  assign sign     = raw_word[RAW_W-1];
  assign mag      = sign ? (~raw_word + 1'b1) : raw_word;
  assign int_part = mag[10:4];
  assign tens     = int_part / 7'd10;
  assign units    = int_part % 7'd10;
  assign frac_x10 = {4'b0000, mag[3:0]} * 8'd10;

  always_ff @(posedge clk or negedge rstn)
  begin
    if (!rstn)
    begin
      temperature <= '0;
      temp_valid  <= 1'b0;
    end
    else
    begin
      temp_valid <= raw_valid;
      if (raw_valid)
        temperature <= {sign, 3'b000, tens[3:0], units[3:0], frac_x10[7:4]};
    end
  end

endmodule

`default_nettype wire

// File: design/us_tick_gen.sv
`timescale 1ns/1ps
`default_nettype none

module us_tick_gen #(
  parameter int CLK_PER_US = 20
) (
  input  logic clk,
  input  logic rstn,
  output logic us_tick
);

  localparam int CNT_W = (CLK_PER_US > 1) ? $clog2(CLK_PER_US) : 1;
  localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(CLK_PER_US - 1);

  logic [CNT_W-1:0] cnt;

  always_ff @(posedge clk or negedge rstn)
  begin
    if (!rstn)
    begin
      cnt     <= '0;
      us_tick <= 1'b0;
    end
    else
    begin
      us_tick <= (cnt == CNT_LAST);  // one cycle per wrap
      if (cnt == CNT_LAST)
        cnt <= '0;
      else
        cnt <= cnt + 1'b1;
    end
  end

endmodule

`default_nettype wire

// File: dv/ds18b20_model.sv
`timescale 1ns/1ps
`default_nettype none

module ds18b20_model #(
  parameter int CLK_PER_US = 20
) (
  input  logic                          clk,
  input  logic                          rstn,
  input  logic                          bus_pull_low,
  input  logic                          present_en,
  input  logic [onewire_pkg::RAW_W-1:0] raw_word,
  output logic                          bus_in
);

  import onewire_pkg::*;

  localparam int RESET_MIN = 300 * CLK_PER_US;  // low cycles that count as a reset
  localparam int ZERO_MIN  = 40 * CLK_PER_US;   // longer low is a write-0
  localparam int PD_WAIT   = 20 * CLK_PER_US;
  localparam int PD_LEN    = 120 * CLK_PER_US;
  localparam int RD_HOLD   = 30 * CLK_PER_US;   // 0 bit held past the sample point

  logic [7:0] byte_q[$];        // written command bytes
  time        byte_time_q[$];   // end of each byte
  time        reset_time_q[$];  // start of each reset pulse

  logic       model_low;
  logic       pull_q;
  logic       read_mode;
  logic [7:0] shreg;
  logic [7:0] next_byte;
  int         low_cycles;
  int         wr_bits;
  int         rd_idx;
  int         win_cnt;
  int         win_begin;
  int         win_end;
  time        slot_t0;

  assign model_low = (win_cnt >= win_begin) && (win_cnt < win_end);

  always @(posedge clk or negedge rstn)
  begin
    if (!rstn)
    begin
      bus_in     <= 1'b1;
      pull_q     <= 1'b0;
      read_mode  <= 1'b0;
      shreg      <= '0;
      low_cycles <= 0;
      wr_bits    <= 0;
      rd_idx     <= 0;
      win_cnt    <= 0;
      win_begin  <= 0;
      win_end    <= 0;
      slot_t0    <= 0;
    end
    else
    begin
      pull_q <= bus_pull_low;
      bus_in <= ~(bus_pull_low | model_low);  // wired AND of both lines
      if (win_cnt < win_end)
        win_cnt <= win_cnt + 1;

      if (bus_pull_low && !pull_q)
      begin
        slot_t0    <= $time;
        low_cycles <= 1;
        if (read_mode && (rd_idx < RAW_W))
        begin
          rd_idx <= rd_idx + 1;
          if (!raw_word[rd_idx])
          begin
            win_cnt   <= 0;  // pull low for a 0 bit
            win_begin <= 0;
            win_end   <= RD_HOLD;
          end
        end
      end
      else if (bus_pull_low)
        low_cycles <= low_cycles + 1;
      else if (pull_q)
      begin
        if (low_cycles >= RESET_MIN)
        begin
          reset_time_q.push_back(slot_t0);
          wr_bits   <= 0;
          rd_idx    <= 0;
          read_mode <= 1'b0;
          if (present_en)
          begin
            win_cnt   <= 0;  // presence pulse
            win_begin <= PD_WAIT;
            win_end   <= PD_WAIT + PD_LEN;
          end
        end
        else if (!read_mode)
        begin
          next_byte = {(low_cycles < ZERO_MIN), shreg[7:1]};  // lsb first
          shreg   <= next_byte;
          wr_bits <= wr_bits + 1;
          if (wr_bits == 7)
          begin
            wr_bits <= 0;
            byte_q.push_back(next_byte);
            byte_time_q.push_back($time);
            if (next_byte == CMD_READ_SCRATCH)
              read_mode <= 1'b1;
          end
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: dv/ds18b20_reader_props.sv
`timescale 1ns/1ps
`default_nettype none

module ds18b20_reader_props (
  input logic                  clk,
  input logic                  rstn,
  input logic                  us_tick,
  input logic                  slot_start,
  input onewire_pkg::slot_op_t slot_op,
  input logic                  bus_pull_low,
  input logic                  slot_done
);

  import onewire_pkg::*;

  logic [US_W-1:0] low_ticks;  // ticks seen while held low
  logic            in_slot;
  slot_op_t        op_q;
  int              fail_cnt;

  always_ff @(posedge clk or negedge rstn)
  begin
    if (!rstn)
    begin
      low_ticks <= '0;
      in_slot   <= 1'b0;
      op_q      <= SLOT_RESET;
    end
    else
    begin
      if (!bus_pull_low)
        low_ticks <= '0;
      else if (us_tick)
        low_ticks <= low_ticks + 1'b1;
      if (slot_start)
      begin
        in_slot <= 1'b1;
        op_q    <= slot_op;
      end
      else if (slot_done)
        in_slot <= 1'b0;
    end
  end

  initial fail_cnt = 0;

  // --------------------
  a_low_limit: assert property (@(posedge clk) disable iff (!rstn)
    low_ticks <= RESET_LOW_US + 1'b1)
  else
  begin
    $error("bus held low longer than a reset pulse");
    fail_cnt++;
  end

  a_write_low: assert property (@(posedge clk) disable iff (!rstn)
    (op_q != SLOT_RESET) |-> (low_ticks <= WRITE_SLOT_US + 1'b1))
  else
  begin
    $error("bus held low longer than a write slot");
    fail_cnt++;
  end

  a_start_idle: assert property (@(posedge clk) disable iff (!rstn)
    slot_start |-> !in_slot)
  else
  begin
    $error("slot_start while a slot is in progress");
    fail_cnt++;
  end

  a_done_pulse: assert property (@(posedge clk) disable iff (!rstn)
    slot_done |=> !slot_done)
  else
  begin
    $error("slot_done longer than one cycle");
    fail_cnt++;
  end

endmodule

`default_nettype wire

// File: dv/tb_clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
  parameter int PERIOD_NS    = 8,
  parameter int RESET_CYCLES = 4
) (
  output logic clk,
  output logic rstn
);

  initial
  begin
    clk  = 1'b0;
    rstn <= 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    rstn <= 1'b1;  // release on a rising edge
  end

  always #(PERIOD_NS / 2) clk = ~clk;

endmodule

`default_nettype wire

// File: dv/tb_ds18b20_reader.sv
`timescale 1ns/1ps
`default_nettype none

module tb_ds18b20_reader;

  import onewire_pkg::*;

  localparam int  CLK_PER_US   = 4;
  localparam int  CONV_WAIT_US = 200;
  localparam int  PERIOD_NS    = 8;
  localparam int  READ_LIMIT   = 60000;  // clk cycles for about two command cycles
  localparam int  PD_LIMIT     = 10000;  // clk cycles for about two reset slots
  localparam time CONV_NS      = 64'(CONV_WAIT_US * CLK_PER_US * PERIOD_NS);

  logic        clk;
  logic        rstn;
  logic        bus_in;
  logic        bus_pull_low;
  logic        temp_valid;
  logic        no_device;
  logic [15:0] temperature;
  logic        present_en;
  logic [15:0] model_raw;
  int          checks;
  int          mismatches;
  int          timeouts;
  int          total_errors;

  tb_clk_gen #(
    .PERIOD_NS    (PERIOD_NS),
    .RESET_CYCLES (4)
  ) i_clk_gen (
    .clk  (clk),
    .rstn (rstn)
  );

  ds18b20_reader #(
    .CLK_PER_US   (CLK_PER_US),
    .CONV_WAIT_US (CONV_WAIT_US)
  ) i_dut (
    .clk          (clk),
    .rstn         (rstn),
    .bus_in       (bus_in),
    .bus_pull_low (bus_pull_low),
    .temp_valid   (temp_valid),
    .no_device    (no_device),
    .temperature  (temperature)
  );

  ds18b20_model #(
    .CLK_PER_US (CLK_PER_US)
  ) i_model (
    .clk          (clk),
    .rstn         (rstn),
    .bus_pull_low (bus_pull_low),
    .present_en   (present_en),
    .raw_word     (model_raw),
    .bus_in       (bus_in)
  );

  bind onewire_slot_engine ds18b20_reader_props i_props (
    .clk          (clk),
    .rstn         (rstn),
    .us_tick      (us_tick),
    .slot_start   (slot_start),
    .slot_op      (slot_op),
    .bus_pull_low (bus_pull_low),
    .slot_done    (slot_done)
  );

  // --------------------
  // sign, tens, units and tenths from the sign bit and the magnitude parts
  function automatic logic [15:0] expected_temp(input logic neg, input int whole,
                                                input int frac);
    int tenths;
    tenths = (frac * 10) / 16;
    return {neg, 3'b000, 4'(whole / 10), 4'(whole % 10), 4'(tenths)};
  endfunction

  task automatic compare_temp(input logic [15:0] got, input logic [15:0] exp,
                              input string what);
    checks++;
    if (got !== exp)
    begin
      mismatches++;
      $display("[FAIL] %0d ns: %s temperature %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic compare_byte(input logic [7:0] got, input logic [7:0] exp, input int idx);
    checks++;
    if (got !== exp)
    begin
      mismatches++;
      $display("[FAIL] %0d ns: command byte %0d is %h, expected %h", $time, idx, got, exp);
    end
  endtask

  task automatic compare_gap(input time gap, input time min_gap);
    checks++;
    if (gap < min_gap)
    begin
      mismatches++;
      $display("[FAIL] %0d ns: reset %0d ns after convert, expected at least %0d ns",
               $time, gap, min_gap);
    end
  endtask

  task automatic wait_temp_valid(output logic seen);
    int n;
    seen = 1'b0;
    n    = 0;
    while (!seen && (n < READ_LIMIT))
    begin
      @(negedge clk);
      seen = temp_valid;
      n++;
    end
    if (!seen)
    begin
      timeouts++;
      $display("timeout at %0d ns: temp_valid never came", $time);
    end
  endtask

  task automatic read_and_check(input logic [15:0] raw, input logic [15:0] exp,
                                input string what);
    logic seen;
    @(posedge clk);
    model_raw <= raw;
    wait_temp_valid(seen);
    if (seen)
      compare_temp(temperature, exp, what);
  endtask

  // --------------------
  task automatic test_command_order();
    int   first;
    int   r;
    time  t44;
    first = i_model.byte_q.size();
    read_and_check(16'h0191, 16'h0250, "command cycle");
    if (i_model.byte_q.size() != first + 4)
    begin
      mismatches++;
      $display("[FAIL] %0d ns: %0d command bytes in one cycle, expected 4",
               $time, i_model.byte_q.size() - first);
      return;
    end
    compare_byte(i_model.byte_q[first], CMD_SKIP_ROM, 0);
    compare_byte(i_model.byte_q[first + 1], CMD_CONVERT_T, 1);
    compare_byte(i_model.byte_q[first + 2], CMD_SKIP_ROM, 2);
    compare_byte(i_model.byte_q[first + 3], CMD_READ_SCRATCH, 3);
    t44 = i_model.byte_time_q[first + 1];
    r   = 0;
    while ((r < i_model.reset_time_q.size()) && (i_model.reset_time_q[r] <= t44))
      r++;
    if (r < i_model.reset_time_q.size())
      compare_gap(i_model.reset_time_q[r] - t44, CONV_NS);
    else
    begin
      mismatches++;
      $display("no reset pulse followed the convert command");
    end
  endtask

  task automatic test_no_device();
    logic seen;
    logic stray;
    int   n;
    @(posedge clk);
    present_en <= 1'b0;
    stray = 1'b0;
    for (int p = 0; p < 3; p++)
    begin
      seen = 1'b0;
      n    = 0;
      while (!seen && (n < PD_LIMIT))
      begin
        @(negedge clk);
        seen  = no_device;
        stray = stray | temp_valid;
        n++;
      end
      if (!seen)
      begin
        timeouts++;
        $display("timeout at %0d ns: no_device pulse %0d never came", $time, p);
      end
    end
    if (stray)
    begin
      mismatches++;
      $display("temp_valid pulsed while the sensor was absent");
    end
    @(posedge clk);
    present_en <= 1'b1;
    read_and_check(16'h0191, 16'h0250, "presence back");
  endtask

  task automatic test_random_readings();
    logic [15:0] mag;
    logic [15:0] raw;
    int          whole;
    int          frac;
    for (int i = 0; i < 12; i++)
    begin
      whole = int'($urandom % 126);
      frac  = int'($urandom % 16);
      mag   = 16'((whole << 4) | frac);
      raw   = (i % 2 == 1) ? -mag : mag;  // alternate signs
      read_and_check(raw, expected_temp(raw[15], whole, frac), "random");
    end
  endtask

  initial
  begin
    checks     = 0;
    mismatches = 0;
    timeouts   = 0;
    present_en <= 1'b1;
    model_raw  <= 16'h0191;
    void'($urandom(7269));
    read_and_check(16'h0191, 16'h0250, "positive");
    read_and_check(16'hFF5E, 16'h8101, "negative");
    test_command_order();
    test_no_device();
    test_random_readings();
    total_errors = mismatches + timeouts + i_dut.i_slot_engine.i_props.fail_cnt;
    $display("checks %0d, mismatches %0d, timeouts %0d, assertion failures %0d",
             checks, mismatches, timeouts, i_dut.i_slot_engine.i_props.fail_cnt);
    if (total_errors == 0)
      $display("No errors");
    else
      $display("Errors found");
    $finish;
  end

endmodule

`default_nettype wire

// File: vlog.f
design/onewire_pkg.sv
design/us_tick_gen.sv
design/onewire_slot_engine.sv
design/ds18b20_sequencer.sv
design/temp_formatter.sv
design/ds18b20_reader.sv
dv/tb_clk_gen.sv
dv/ds18b20_model.sv
dv/ds18b20_reader_props.sv
dv/tb_ds18b20_reader.sv
